//--- verilog/core_pkg.sv
package core_pkg;

    // 3R opcodes, top 17 bits of the word
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002A;
    localparam logic [16:0] OPC_XOR   = 17'h0002B;

    // 2RI12 opcodes, top 10 bits of the word
    localparam logic [9:0] OPC_ADDI_W = 10'h00A;
    localparam logic [9:0] OPC_LD_W   = 10'h0A2;
    localparam logic [9:0] OPC_ST_W   = 10'h0A6;
    localparam logic [9:0] OPC_LL_W   = 10'h080;
    localparam logic [9:0] OPC_SC_W   = 10'h084;

    localparam logic [5:0] ECODE_INE = 6'h0D;
    localparam logic [5:0] ECODE_ALE = 6'h09;

    localparam int DMEM_WORDS = 16;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } instr_r3_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } instr_ri12_t;

    // same word, two field layouts
    typedef union packed {
        instr_r3_t   r3;
        instr_ri12_t ri12;
    } instr_u;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_ADDI, OP_LD, OP_ST, OP_LL, OP_SC,
        OP_NONE
    } op_e;

endpackage

//--- verilog/exwb_if.sv
`timescale 1ns/10ps

interface exwb_if
    import core_pkg::*;
();

    logic        valid;
    logic [31:0] pc;
    op_e         op;
    logic        we;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        excp;
    logic [5:0]  ecode;
    logic [31:0] mem_addr;

    modport ex_mp (
        output valid, pc, op, we, waddr, wdata, excp, ecode, mem_addr
    );

    modport wb_mp (
        input valid, pc, op, we, waddr, wdata, excp, ecode, mem_addr
    );

endinterface

//--- verilog/instr_decode.sv
`timescale 1ns/10ps

module instr_decode
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  logic        instr_valid_i,
    input  instr_u      instr_i,
    input  logic [31:0] pc_i,
    output logic        dec_valid_o,
    output op_e         dec_op_o,
    output logic [4:0]  dec_rj_o,
    output logic [4:0]  dec_rk_o,
    output logic [4:0]  dec_rd_o,
    output logic [31:0] dec_imm_o,
    output logic        dec_we_o,
    output logic        dec_ine_o,
    output logic [31:0] dec_pc_o
);

    op_e         op;
    logic [4:0]  rk_sel;
    logic [31:0] imm;
    logic        we;

    always_comb begin
        op = OP_NONE;
        // 17-bit view first, the 10-bit view only if nothing matched
        case (instr_i.r3.opcode)
            OPC_ADD_W: op = OP_ADD;
            OPC_SUB_W: op = OP_SUB;
            OPC_AND:   op = OP_AND;
            OPC_OR:    op = OP_OR;
            OPC_XOR:   op = OP_XOR;
            default: begin
                case (instr_i.ri12.opcode)
                    OPC_ADDI_W: op = OP_ADDI;
                    OPC_LD_W:   op = OP_LD;
                    OPC_ST_W:   op = OP_ST;
                    OPC_LL_W:   op = OP_LL;
                    OPC_SC_W:   op = OP_SC;
                    default:    op = OP_NONE;
                endcase
            end
        endcase

        imm = {{20{instr_i.ri12.si12[11]}}, instr_i.ri12.si12};

        // store data comes from rd
        if (op == OP_ST || op == OP_SC) begin
            rk_sel = instr_i.ri12.rd;
        end else begin
            rk_sel = instr_i.r3.rk;
        end

        we = (op != OP_NONE) && (op != OP_ST) && (instr_i.r3.rd != 5'd0);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_valid_o <= 1'b0;
            dec_we_o    <= 1'b0;
            dec_ine_o   <= 1'b0;
        end else if (flush_i) begin
            dec_valid_o <= 1'b0;
            dec_we_o    <= 1'b0;
        end else if (!stall_i) begin
            dec_valid_o <= instr_valid_i;
            dec_we_o    <= instr_valid_i && we;
            dec_ine_o   <= op == OP_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            dec_op_o  <= op;
            dec_rj_o  <= instr_i.r3.rj;
            dec_rk_o  <= rk_sel;
            dec_rd_o  <= instr_i.r3.rd;
            dec_imm_o <= imm;
            dec_pc_o  <= pc_i;
        end
    end

    // an undecoded word must reach execute flagged
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (dec_valid_o && dec_op_o == OP_NONE) |-> dec_ine_o);

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/10ps

module exec_unit
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  logic        dec_valid_i,
    input  op_e         dec_op_i,
    input  logic [4:0]  dec_rj_i,
    input  logic [4:0]  dec_rk_i,
    input  logic [4:0]  dec_rd_i,
    input  logic [31:0] dec_imm_i,
    input  logic        dec_we_i,
    input  logic        dec_ine_i,
    input  logic [31:0] dec_pc_i,
    input  logic [31:0] rd_a_i,
    input  logic [31:0] rd_b_i,
    output logic [4:0]  ra_o,
    output logic [4:0]  rb_o,
    input  logic        fwd_we_i,
    input  logic [4:0]  fwd_waddr_i,
    input  logic [31:0] fwd_wdata_i,
    input  logic        llbit_eff_i,
    exwb_if.ex_mp       exwb
);

    logic [31:0] dmem [DMEM_WORDS];

    logic [31:0]        src_a;
    logic [31:0]        src_b;
    logic [31:0]        mem_addr;
    logic [DMEM_AW-1:0] mem_idx;
    logic               is_mem;
    logic               ale;
    logic               excp;
    logic               sc_ok;
    logic               store_en;
    logic [31:0]        result;

    assign ra_o = dec_rj_i;
    assign rb_o = dec_rk_i;

    // bypass from the instruction one stage ahead
    assign src_a = (fwd_we_i && fwd_waddr_i == dec_rj_i) ? fwd_wdata_i : rd_a_i;
    assign src_b = (fwd_we_i && fwd_waddr_i == dec_rk_i) ? fwd_wdata_i : rd_b_i;

    assign mem_addr = src_a + dec_imm_i;
    assign mem_idx  = mem_addr[DMEM_AW+1:2];
    assign is_mem   = dec_op_i inside {OP_LD, OP_ST, OP_LL, OP_SC};
    assign ale      = is_mem && (mem_addr[1:0] != 2'b00);
    assign excp     = dec_ine_i || ale;
    assign sc_ok    = (dec_op_i == OP_SC) && llbit_eff_i;

    assign store_en = dec_valid_i && !stall_i && !flush_i && !excp
                      && (dec_op_i == OP_ST || sc_ok);

    always_comb begin
        case (dec_op_i)
            OP_ADD:  result = src_a + src_b;
            OP_SUB:  result = src_a - src_b;
            OP_AND:  result = src_a & src_b;
            OP_OR:   result = src_a | src_b;
            OP_XOR:  result = src_a ^ src_b;
            OP_ADDI: result = mem_addr;
            OP_LD:   result = dmem[mem_idx];
            OP_LL:   result = dmem[mem_idx];
            OP_SC:   result = {31'd0, sc_ok};
            default: result = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            dmem[mem_idx] <= src_b;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exwb.valid <= 1'b0;
            exwb.we    <= 1'b0;
        end else if (flush_i) begin
            exwb.valid <= 1'b0;
            exwb.we    <= 1'b0;
        end else if (!stall_i) begin
            exwb.valid <= dec_valid_i;
            // excepting instructions never write rd
            exwb.we    <= dec_valid_i && dec_we_i && !excp;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            exwb.pc       <= dec_pc_i;
            exwb.op       <= dec_op_i;
            exwb.waddr    <= dec_rd_i;
            exwb.wdata    <= result;
            exwb.excp     <= excp;
            exwb.ecode    <= dec_ine_i ? ECODE_INE : ECODE_ALE;
            exwb.mem_addr <= mem_addr;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n_i)
        store_en |-> mem_addr[1:0] == 2'b00);

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [4:0]  ra_i,
    input  logic [4:0]  rb_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rd_a_o,
    output logic [31:0] rd_b_o
);

    logic [31:0] regs [32];

    // r0 first, then the word being written this cycle
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (we_i && waddr_i == addr) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    assign rd_a_o = read_port(ra_i);
    assign rd_b_o = read_port(rb_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

//--- verilog/wb_stage.sv
`timescale 1ns/10ps

module wb_stage
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    exwb_if.wb_mp       exwb,
    output logic        fwd_we_o,
    output logic [4:0]  fwd_waddr_o,
    output logic [31:0] fwd_wdata_o,
    output logic        llbit_eff_o,
    output logic        llbit_o,
    output logic        commit_valid_o,
    output logic [31:0] commit_pc_o,
    output logic        commit_we_o,
    output logic [4:0]  commit_waddr_o,
    output logic [31:0] commit_wdata_o,
    output logic        commit_excp_o,
    output logic [5:0]  commit_ecode_o,
    output logic [31:0] commit_mem_addr_o,
    output logic        cache_flush_o
);

    logic llbit_q;
    logic ll_set;
    logic sc_clr;
    logic commit_valid_q;
    logic commit_we_q;

    // in-flight result goes straight back to execute
    assign fwd_we_o    = exwb.we;
    assign fwd_waddr_o = exwb.waddr;
    assign fwd_wdata_o = exwb.wdata;

    assign ll_set = exwb.valid && !exwb.excp && exwb.op == OP_LL;
    assign sc_clr = exwb.valid && !exwb.excp && exwb.op == OP_SC;

    // sc.w in execute must see the effect of ll.w/sc.w just ahead of it
    always_comb begin
        if (ll_set) begin
            llbit_eff_o = 1'b1;
        end else if (sc_clr) begin
            llbit_eff_o = 1'b0;
        end else begin
            llbit_eff_o = llbit_q;
        end
    end

    assign llbit_o = llbit_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            llbit_q <= 1'b0;
        end else if (!flush_i && !stall_i) begin
            llbit_q <= llbit_eff_o;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_valid_q <= 1'b0;
            commit_we_q    <= 1'b0;
            commit_excp_o  <= 1'b0;
        end else if (flush_i) begin
            commit_valid_q <= 1'b0;
            commit_we_q    <= 1'b0;
            commit_excp_o  <= 1'b0;
        end else if (!stall_i) begin
            commit_valid_q <= exwb.valid;
            commit_we_q    <= exwb.we;
            commit_excp_o  <= exwb.valid && exwb.excp;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            commit_pc_o       <= exwb.pc;
            commit_waddr_o    <= exwb.waddr;
            commit_wdata_o    <= exwb.wdata;
            commit_ecode_o    <= exwb.ecode;
            commit_mem_addr_o <= exwb.mem_addr;
        end
    end

    // held record shows once, after the stall lifts
    assign commit_valid_o = commit_valid_q && !stall_i;
    assign commit_we_o    = commit_we_q && !stall_i;
    assign cache_flush_o  = commit_valid_o && commit_excp_o;

    // rd 0 writes are dropped back in decode
    assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_we_o |-> commit_waddr_o != 5'd0);

endmodule

//--- verilog/core_slice_top.sv
`timescale 1ns/10ps

module core_slice_top
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        stall_i,
    input  logic        flush_i,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    output logic        commit_valid_o,
    output logic [31:0] commit_pc_o,
    output logic        commit_we_o,
    output logic [4:0]  commit_waddr_o,
    output logic [31:0] commit_wdata_o,
    output logic        commit_excp_o,
    output logic [5:0]  commit_ecode_o,
    output logic [31:0] commit_mem_addr_o,
    output logic        llbit_o,
    output logic        cache_flush_o
);

    logic        dec_valid;
    op_e         dec_op;
    logic [4:0]  dec_rj;
    logic [4:0]  dec_rk;
    logic [4:0]  dec_rd;
    logic [31:0] dec_imm;
    logic        dec_we;
    logic        dec_ine;
    logic [31:0] dec_pc;

    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] rd_a;
    logic [31:0] rd_b;

    logic        fwd_we;
    logic [4:0]  fwd_waddr;
    logic [31:0] fwd_wdata;
    logic        llbit_eff;

    exwb_if exwb ();

    instr_decode instr_decode_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .dec_valid_o   (dec_valid),
        .dec_op_o      (dec_op),
        .dec_rj_o      (dec_rj),
        .dec_rk_o      (dec_rk),
        .dec_rd_o      (dec_rd),
        .dec_imm_o     (dec_imm),
        .dec_we_o      (dec_we),
        .dec_ine_o     (dec_ine),
        .dec_pc_o      (dec_pc)
    );

    exec_unit exec_unit_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .dec_valid_i (dec_valid),
        .dec_op_i    (dec_op),
        .dec_rj_i    (dec_rj),
        .dec_rk_i    (dec_rk),
        .dec_rd_i    (dec_rd),
        .dec_imm_i   (dec_imm),
        .dec_we_i    (dec_we),
        .dec_ine_i   (dec_ine),
        .dec_pc_i    (dec_pc),
        .rd_a_i      (rd_a),
        .rd_b_i      (rd_b),
        .ra_o        (ra),
        .rb_o        (rb),
        .fwd_we_i    (fwd_we),
        .fwd_waddr_i (fwd_waddr),
        .fwd_wdata_i (fwd_wdata),
        .llbit_eff_i (llbit_eff),
        .exwb        (exwb.ex_mp)
    );

    // write port fed by the commit record
    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .ra_i    (ra),
        .rb_i    (rb),
        .we_i    (commit_we_o),
        .waddr_i (commit_waddr_o),
        .wdata_i (commit_wdata_o),
        .rd_a_o  (rd_a),
        .rd_b_o  (rd_b)
    );

    wb_stage wb_stage_inst (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .exwb              (exwb.wb_mp),
        .fwd_we_o          (fwd_we),
        .fwd_waddr_o       (fwd_waddr),
        .fwd_wdata_o       (fwd_wdata),
        .llbit_eff_o       (llbit_eff),
        .llbit_o           (llbit_o),
        .commit_valid_o    (commit_valid_o),
        .commit_pc_o       (commit_pc_o),
        .commit_we_o       (commit_we_o),
        .commit_waddr_o    (commit_waddr_o),
        .commit_wdata_o    (commit_wdata_o),
        .commit_excp_o     (commit_excp_o),
        .commit_ecode_o    (commit_ecode_o),
        .commit_mem_addr_o (commit_mem_addr_o),
        .cache_flush_o     (cache_flush_o)
    );

endmodule

//--- test/tb_core_slice.sv
`timescale 1ns/10ps

module tb_core_slice
    import core_pkg::*;
();

    localparam int          HALF_PERIOD = 50;
    localparam int          NUM_PASSES  = 2;
    localparam logic [31:0] PC_BASE     = 32'h1c00_0000;

    // entry kinds
    localparam int K_INSTR = 0;
    localparam int K_DROP  = 1;
    localparam int K_FLUSH = 2;

    typedef struct packed {
        int          kind;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
        logic        excp;
        logic [5:0]  ecode;
        logic        llbit;
        logic        chk_addr;
        logic [31:0] mem_addr;
    } entry_t;

    logic        clk;
    logic        rst_n_i;
    logic        stall_i;
    logic        flush_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        commit_valid_o;
    logic [31:0] commit_pc_o;
    logic        commit_we_o;
    logic [4:0]  commit_waddr_o;
    logic [31:0] commit_wdata_o;
    logic        commit_excp_o;
    logic [5:0]  commit_ecode_o;
    logic [31:0] commit_mem_addr_o;
    logic        llbit_o;
    logic        cache_flush_o;

    entry_t prog[$];
    entry_t exp_q[$];
    int     ck_idx = 0;
    int     seed = 56;
    bit     tbl_ready = 1'b0;

    core_slice_top core_slice_top_inst (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .stall_i           (stall_i),
        .flush_i           (flush_i),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .pc_i              (pc_i),
        .commit_valid_o    (commit_valid_o),
        .commit_pc_o       (commit_pc_o),
        .commit_we_o       (commit_we_o),
        .commit_waddr_o    (commit_waddr_o),
        .commit_wdata_o    (commit_wdata_o),
        .commit_excp_o     (commit_excp_o),
        .commit_ecode_o    (commit_ecode_o),
        .commit_mem_addr_o (commit_mem_addr_o),
        .llbit_o           (llbit_o),
        .cache_flush_o     (cache_flush_o)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    function automatic logic [31:0] r3_word(input logic [16:0] opc, input int rd,
                                            input int rj, input int rk);
        return {opc, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] opc, input int rd,
                                              input int rj, input int si12);
        return {opc, 12'(si12), 5'(rj), 5'(rd)};
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        assert (got === want)
        else report_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
                                    name, got, want));
    endtask

    task automatic add_entry(input int kind, input logic [31:0] instr, input int we,
                             input int waddr, input logic [31:0] wdata, input int excp,
                             input logic [5:0] ecode, input int llbit, input int chk,
                             input logic [31:0] maddr);
        entry_t e;
        e.kind     = kind;
        e.instr    = instr;
        e.pc       = PC_BASE + 32'(prog.size() * 4);
        e.we       = we[0];
        e.waddr    = waddr[4:0];
        e.wdata    = wdata;
        e.excp     = excp[0];
        e.ecode    = ecode;
        e.llbit    = llbit[0];
        e.chk_addr = chk[0];
        e.mem_addr = maddr;
        prog.push_back(e);
    endtask

    task automatic build_table();
        // kind, instr, we, waddr, wdata, excp, ecode, llbit, check mem_addr, mem_addr
        add_entry(K_INSTR, ri12_word(OPC_ADDI_W, 1, 0, 'h123), 1, 1, 32'h123, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, ri12_word(OPC_ADDI_W, 2, 0, -4), 1, 2, 32'hffff_fffc, 0, 6'h0, 0, 0, 0);
        // r2 from the forward path, r1 from the commit port
        add_entry(K_INSTR, r3_word(OPC_ADD_W, 3, 1, 2), 1, 3, 32'h11f, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, r3_word(OPC_SUB_W, 4, 3, 1), 1, 4, 32'hffff_fffc, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, r3_word(OPC_AND, 5, 4, 1), 1, 5, 32'h120, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, r3_word(OPC_OR, 6, 5, 3), 1, 6, 32'h13f, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, r3_word(OPC_XOR, 7, 6, 1), 1, 7, 32'h01c, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, r3_word(OPC_ADD_W, 0, 1, 1), 0, 0, 32'h0, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, ri12_word(OPC_ADDI_W, 8, 0, 'h10), 1, 8, 32'h10, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, ri12_word(OPC_ST_W, 6, 8, 4), 0, 0, 32'h0, 0, 6'h0, 0, 1, 32'h14);
        add_entry(K_INSTR, ri12_word(OPC_LD_W, 9, 8, 4), 1, 9, 32'h13f, 0, 6'h0, 0, 1, 32'h14);
        // misaligned store must leave the word alone
        add_entry(K_INSTR, ri12_word(OPC_ST_W, 1, 8, 6), 0, 0, 32'h0, 1, ECODE_ALE, 0, 1, 32'h16);
        add_entry(K_INSTR, ri12_word(OPC_LD_W, 10, 8, 4), 1, 10, 32'h13f, 0, 6'h0, 0, 1, 32'h14);
        add_entry(K_INSTR, ri12_word(OPC_LD_W, 11, 8, 2), 0, 0, 32'h0, 1, ECODE_ALE, 0, 1, 32'h12);
        add_entry(K_INSTR, 32'hffff_ffff, 0, 0, 32'h0, 1, ECODE_INE, 0, 0, 0);
        add_entry(K_INSTR, ri12_word(OPC_LL_W, 12, 8, 4), 1, 12, 32'h13f, 0, 6'h0, 1, 1, 32'h14);
        add_entry(K_INSTR, ri12_word(OPC_SC_W, 7, 8, 8), 1, 7, 32'h1, 0, 6'h0, 0, 1, 32'h18);
        add_entry(K_INSTR, ri12_word(OPC_SC_W, 3, 8, 8), 1, 3, 32'h0, 0, 6'h0, 0, 1, 32'h18);
        add_entry(K_INSTR, ri12_word(OPC_ST_W, 5, 8, 12), 0, 0, 32'h0, 0, 6'h0, 0, 1, 32'h1c);
        add_entry(K_INSTR, ri12_word(OPC_LD_W, 13, 8, 8), 1, 13, 32'h1c, 0, 6'h0, 0, 1, 32'h18);
        // both dropped by the flush, the store is still in execute then
        add_entry(K_DROP, ri12_word(OPC_ADDI_W, 14, 0, 'h55), 1, 14, 32'h55, 0, 6'h0, 0, 0, 0);
        add_entry(K_DROP, ri12_word(OPC_ST_W, 2, 8, 12), 0, 0, 32'h0, 0, 6'h0, 0, 0, 0);
        add_entry(K_FLUSH, 32'h0, 0, 0, 32'h0, 0, 6'h0, 0, 0, 0);
        add_entry(K_INSTR, ri12_word(OPC_LD_W, 15, 8, 12), 1, 15, 32'h120, 0, 6'h0, 0, 1, 32'h1c);
        add_entry(K_INSTR, r3_word(OPC_ADD_W, 16, 14, 13), 1, 16, 32'h1c, 0, 6'h0, 0, 0, 0);
        // zero the used words so the next pass has to store them again
        add_entry(K_INSTR, ri12_word(OPC_ST_W, 0, 8, 4), 0, 0, 32'h0, 0, 6'h0, 0, 1, 32'h14);
        add_entry(K_INSTR, ri12_word(OPC_ST_W, 0, 8, 8), 0, 0, 32'h0, 0, 6'h0, 0, 1, 32'h18);
        add_entry(K_INSTR, ri12_word(OPC_ST_W, 0, 8, 12), 0, 0, 32'h0, 0, 6'h0, 0, 1, 32'h1c);
        foreach (prog[i]) begin
            if (prog[i].kind == K_INSTR) begin
                exp_q.push_back(prog[i]);
            end
        end
    endtask

    task automatic apply_reset();
        ck_idx = 0;
        rst_n_i       <= 1'b0;
        stall_i       <= 1'b0;
        flush_i       <= 1'b0;
        instr_valid_i <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
    endtask

    task automatic run_program(input bit stall_on);
        for (int i = 0; i < prog.size(); i++) begin
            // no stall inside the flush sequence
            if (stall_on && prog[i].kind == K_INSTR) begin
                while (($random(seed) & 3) == 0) begin
                    @(posedge clk);
                    stall_i       <= 1'b1;
                    flush_i       <= 1'b0;
                    instr_valid_i <= 1'b0;
                end
            end
            @(posedge clk);
            stall_i       <= 1'b0;
            flush_i       <= (prog[i].kind == K_FLUSH);
            instr_valid_i <= (prog[i].kind != K_FLUSH);
            instr_i       <= prog[i].instr;
            pc_i          <= prog[i].pc;
        end
        while (ck_idx < exp_q.size()) begin
            @(posedge clk);
            flush_i       <= 1'b0;
            instr_valid_i <= 1'b0;
            stall_i       <= stall_on && (($random(seed) & 3) == 0);
        end
    endtask

    task automatic check_commit(input entry_t e);
        check_val("commit_pc_o", commit_pc_o, e.pc);
        check_val("commit_we_o", 32'(commit_we_o), 32'(e.we));
        if (e.we) begin
            check_val("commit_waddr_o", 32'(commit_waddr_o), 32'(e.waddr));
            check_val("commit_wdata_o", commit_wdata_o, e.wdata);
        end
        check_val("commit_excp_o", 32'(commit_excp_o), 32'(e.excp));
        check_val("cache_flush_o", 32'(cache_flush_o), 32'(e.excp));
        if (e.excp) begin
            check_val("commit_ecode_o", 32'(commit_ecode_o), 32'(e.ecode));
        end
        check_val("llbit_o", 32'(llbit_o), 32'(e.llbit));
        if (e.chk_addr) begin
            check_val("commit_mem_addr_o", commit_mem_addr_o, e.mem_addr);
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n_i) begin
            assert (!(stall_i && commit_valid_o))
            else report_error("a commit appeared while stall_i was high");
            if (commit_valid_o) begin
                assert (ck_idx < exp_q.size())
                else report_error("a commit appeared after the last expected one");
                check_commit(exp_q[ck_idx]);
                ck_idx++;
            end
        end
    end

    initial begin
        int limit;
        wait (tbl_ready);
        limit = NUM_PASSES * (prog.size() * 8 + 20);
        repeat (limit) @(posedge clk);
        report_error($sformatf("timeout: commits are missing, %0d of %0d seen in this pass",
                               ck_idx, exp_q.size()));
    end

    initial begin
        rst_n_i       = 1'b0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        pc_i          = 32'h0;
        build_table();
        tbl_ready = 1'b1;
        // second pass repeats the program under random back-pressure
        for (int pass_no = 0; pass_no < NUM_PASSES; pass_no++) begin
            apply_reset();
            run_program(pass_no == 1);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- compile.f
verilog/core_pkg.sv
verilog/exwb_if.sv
verilog/instr_decode.sv
verilog/exec_unit.sv
verilog/reg_file.sv
verilog/wb_stage.sv
verilog/core_slice_top.sv
test/tb_core_slice.sv

//--- Makefile
# all of these can be overridden on the make command line
VERILATOR ?= verilator
TOP       ?= tb_core_slice
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation result: FAIL"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
